// File: files.f
game_pkg.sv
display_pkg.sv
level_store.sv
note_playback.sv
response_checker.sv
game_controller.sv
segment_display.sv
memory_game.sv
tb_memory_game.sv

// File: Makefile
TOP := tb_memory_game

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f files.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tb_memory_game.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_game;

    localparam int note_cycles      = 4;
    localparam int win_pause_cycles = 8;
    localparam int n_rows           = 3;
    localparam logic [3:0] no_wrong = 4'hf;

    // active-low segment shapes with g in the top bit
    localparam display_pkg::seg_t ch_h     = 7'b000_1001;
    localparam display_pkg::seg_t ch_e     = 7'b000_0110;
    localparam display_pkg::seg_t ch_l     = 7'b100_0111;
    localparam display_pkg::seg_t ch_o     = 7'b100_0000;
    localparam display_pkg::seg_t ch_s     = 7'b001_0010;
    localparam display_pkg::seg_t ch_t     = 7'b000_0111;
    localparam display_pkg::seg_t ch_a     = 7'b000_1000;
    localparam display_pkg::seg_t ch_g     = 7'b100_0010;
    localparam display_pkg::seg_t ch_u     = 7'b100_0001;
    localparam display_pkg::seg_t ch_r     = 7'b010_1111;
    localparam display_pkg::seg_t ch_n     = 7'b010_1011;
    localparam display_pkg::seg_t ch_c     = 7'b100_0110;
    localparam display_pkg::seg_t ch_blank = 7'b111_1111;

    localparam display_pkg::display_t msg_hello = {ch_h, ch_e, ch_l, ch_l, ch_o, ch_blank};
    localparam display_pkg::display_t msg_turn  = {ch_t, ch_u, ch_r, ch_n, ch_blank, ch_blank};
    localparam display_pkg::display_t msg_score = {ch_s, ch_c, ch_o, ch_r, ch_e, ch_blank};
    localparam display_pkg::display_t msg_lose  = {ch_l, ch_o, ch_s, ch_e, ch_blank, ch_blank};
    localparam logic [34:0]           stage_top = {ch_s, ch_t, ch_a, ch_g, ch_e};

    // expected[k] is the k-th level played
    // a length of 0 marks a random level
    typedef struct packed {
        game_pkg::level_num_t   level_select;
        logic [3:0]             wins;
        logic [3:0]             wrong_at;
        game_pkg::level_t [2:0] expected;
    } row_t;

    logic                   clk;
    logic                   load;
    logic                   start_game;
    game_pkg::level_num_t   level_select;
    game_pkg::note_t        buttons;
    game_pkg::note_t        leds;
    display_pkg::display_t  display;

    row_t                   rows [n_rows];
    game_pkg::note_t        recorded [$];
    logic [31:0]            rand_state;
    int                     cycle_count;
    int                     cycle_limit;

    memory_game #(
        .note_cycles      (note_cycles),
        .win_pause_cycles (win_pause_cycles)
    ) i_memory_game (
        .clk          (clk),
        .load         (load),
        .start_game   (start_game),
        .level_select (level_select),
        .buttons      (buttons),
        .leds         (leds),
        .display      (display)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        cycle_count = 0;
        forever
        begin
            @(posedge clk);
            cycle_count++;
            if (cycle_limit != 0 && cycle_count > cycle_limit)
            begin
                $display("timeout: the game did not reach the expected state in %0d cycles",
                         cycle_limit);
                $display("SIMULATION FAILED");
                $fatal(1, "run stopped by the cycle limit");
            end
        end
    end

    task automatic check(
        input string       name,
        input logic [63:0] actual,
        input logic [63:0] expected
    );
        if (actual !== expected)
        begin
            $display("FAIL at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic display_pkg::seg_t digit_seg(input int value);
        case (value)
            0: return 7'b100_0000;
            1: return 7'b111_1001;
            2: return 7'b010_0100;
            3: return 7'b011_0000;
            4: return 7'b001_1001;
            5: return 7'b001_0010;
            6: return 7'b000_0010;
            7: return 7'b111_1000;
            8: return 7'b000_0000;
            9: return 7'b001_1000;
            default: return ch_blank;
        endcase
    endfunction

    function automatic display_pkg::display_t stage_msg(input int level);
        return {stage_top, digit_seg(level)};
    endfunction

    function automatic game_pkg::level_t table_level(
        input logic [3:0]      len,
        input game_pkg::note_t n0,
        input game_pkg::note_t n1,
        input game_pkg::note_t n2,
        input game_pkg::note_t n3,
        input game_pkg::note_t n4,
        input game_pkg::note_t n5
    );
        game_pkg::level_t lvl;
        lvl.length   = len;
        lvl.notes[0] = n0;
        lvl.notes[1] = n1;
        lvl.notes[2] = n2;
        lvl.notes[3] = n3;
        lvl.notes[4] = n4;
        lvl.notes[5] = n5;
        return lvl;
    endfunction

    // any one-hot note other than the right one
    function automatic game_pkg::note_t wrong_note(input game_pkg::note_t right);
        logic [31:0] r;
        logic [7:0]  doubled;
        logic [7:0]  rotated;
        int          shift;
        r       = next_random();
        shift   = 1 + int'(r[17:16]) % 3;
        doubled = {right, right};
        rotated = doubled >> (4 - shift);
        return rotated[3:0];
    endfunction

    function automatic game_pkg::note_t random_note();
        logic [31:0] r;
        r = next_random();
        return 4'b0001 << r[17:16];
    endfunction

    task automatic fill_table();
        game_pkg::level_t rnd;
        rnd = '0;
        rows[0].level_select = 4'd0;
        rows[0].wins         = 4'd2;
        rows[0].wrong_at     = 4'd2;
        rows[0].expected[0]  = table_level(4'd4, 4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0);
        rows[0].expected[1]  = table_level(4'd4, 4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0);
        rows[0].expected[2]  = table_level(4'd5, 4'h1, 4'h2, 4'h2, 4'h1, 4'h1, 4'h0);
        rows[1].level_select = 4'd3;
        rows[1].wins         = 4'd2;
        rows[1].wrong_at     = no_wrong;
        rows[1].expected[0]  = table_level(4'd6, 4'h4, 4'h2, 4'h1, 4'h4, 4'h2, 4'h1);
        rows[1].expected[1]  = rnd;
        rows[1].expected[2]  = rnd;
        rows[2].level_select = 4'd1;
        rows[2].wins         = 4'd0;
        rows[2].wrong_at     = 4'd0;
        rows[2].expected[0]  = table_level(4'd4, 4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0);
        rows[2].expected[1]  = rnd;
        rows[2].expected[2]  = rnd;
    endtask

    // levels played times the longest level and then doubled
    function automatic int timeout_limit();
        int total;
        total = 0;
        for (int r = 0; r < n_rows; r++)
        begin
            total += (int'(rows[r].wins) + 1)
                     * (2 * 6 * note_cycles + 6 * 4 + win_pause_cycles + 10);
        end
        return total * 2;
    endfunction

    task automatic apply_reset(input game_pkg::level_num_t select);
        @(posedge clk);
        load         <= 1'b1;
        level_select <= select;
        buttons      <= '0;
        start_game   <= 1'b0;
        repeat (5) @(posedge clk);
        load <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_game <= 1'b1;
        @(posedge clk);
        start_game <= 1'b0;
    endtask

    // held for two cycles and released on return
    task automatic press_button(input game_pkg::note_t note);
        @(posedge clk);
        buttons <= note;
        repeat (2) @(posedge clk);
        buttons <= '0;
    endtask

    task automatic wait_display(input display_pkg::display_t msg);
        @(negedge clk);
        while (display != msg)
            @(negedge clk);
    endtask

    task automatic wait_stage();
        @(negedge clk);
        while (display[41:7] != stage_top)
            @(negedge clk);
    endtask

    // collect one note per dark-to-lit edge until the turn message
    task automatic record_notes();
        game_pkg::note_t prev_led;
        int              lit;
        recorded.delete();
        prev_led = '0;
        lit      = 0;
        while (display != msg_turn)
        begin
            if (leds != '0)
            begin
                if (prev_led == '0)
                    recorded.push_back(leds);
                lit++;
            end
            else if (prev_led != '0)
            begin
                check("lit cycles", 64'(lit), 64'(note_cycles));
                lit = 0;
            end
            prev_led = leds;
            @(negedge clk);
        end
    endtask

    task automatic verify_notes(input game_pkg::level_t want);
        if (want.length == 4'd0)
        begin
            check("random note count", 64'(recorded.size()), 64'd6);
            for (int i = 0; i < recorded.size(); i++)
                check("random note one-hot", 64'($onehot(recorded[i])), 64'd1);
        end
        else
        begin
            check("note count", 64'(recorded.size()), 64'(want.length));
            for (int i = 0; i < int'(want.length); i++)
                check("leds", 64'(recorded[i]), 64'(want.notes[i]));
        end
    endtask

    task automatic run_row(input row_t row);
        int level_now;
        int pause_len;
        apply_reset(row.level_select);
        @(negedge clk);
        check("display", 64'(display), 64'(msg_hello));
        @(posedge clk);
        buttons <= 4'h9;
        @(negedge clk);
        check("leds", 64'(leds), 64'h0);
        @(negedge clk);
        check("leds", 64'(leds), 64'h9);
        @(posedge clk);
        buttons <= '0;
        pulse_start();
        for (int k = 0; k <= int'(row.wins); k++)
        begin
            level_now = int'(row.level_select) + 1 + k;
            wait_stage();
            check("display", 64'(display), 64'(stage_msg(level_now)));
            record_notes();
            verify_notes(row.expected[k]);
            if (k < int'(row.wins))
            begin
                for (int i = 0; i < recorded.size(); i++)
                begin
                    press_button(recorded[i]);
                    if (i < recorded.size() - 1)
                    begin
                        @(negedge clk);
                        check("display", 64'(display), 64'(msg_turn));
                    end
                end
                wait_display(msg_score);
                pause_len = 0;
                while (display == msg_score)
                begin
                    pause_len++;
                    @(negedge clk);
                end
                check("win pause cycles", 64'(pause_len), 64'(win_pause_cycles));
            end
            else if (row.wrong_at != no_wrong)
            begin
                for (int i = 0; i < int'(row.wrong_at); i++)
                begin
                    press_button(recorded[i]);
                    @(negedge clk);
                    check("display", 64'(display), 64'(msg_turn));
                end
                press_button(wrong_note(recorded[row.wrong_at]));
                wait_display(msg_lose);
                // lost holds through presses and start
                repeat (2)
                begin
                    press_button(random_note());
                    @(negedge clk);
                    check("display", 64'(display), 64'(msg_lose));
                end
                pulse_start();
                @(negedge clk);
                check("display", 64'(display), 64'(msg_lose));
            end
        end
    endtask

    initial
    begin
        cycle_limit  = 0;
        rand_state   = 32'hb9fbbddf;
        load         <= 1'b1;
        start_game   <= 1'b0;
        level_select <= '0;
        buttons      <= '0;
        fill_table();
        cycle_limit = timeout_limit();
        for (int r = 0; r < n_rows; r++)
            run_row(rows[r]);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: memory_game.sv
`timescale 1ns/1ps
`default_nettype none

module memory_game #(
    parameter int note_cycles      = 25000000,
    parameter int win_pause_cycles = 50000000
) (
    input  wire logic                   clk,
    input  wire logic                   load,
    input  wire logic                   start_game,
    input  wire game_pkg::level_num_t   level_select,
    input  wire game_pkg::note_t        buttons,
    output game_pkg::note_t             leds,
    output display_pkg::display_t       display
);

    game_pkg::game_state_e  state;
    logic                   next_level;
    logic                   arm;
    logic                   play;
    logic                   listen;
    game_pkg::level_t       level;
    game_pkg::level_num_t   level_number;
    game_pkg::note_t        play_note;
    logic                   play_done;
    game_pkg::response_t    response;

    game_controller #(
        .win_pause_cycles(win_pause_cycles)
    ) i_game_controller (
        .clk        (clk),
        .load       (load),
        .start_game (start_game),
        .play_done  (play_done),
        .response   (response),
        .buttons    (buttons),
        .play_note  (play_note),
        .state      (state),
        .next_level (next_level),
        .arm        (arm),
        .play       (play),
        .listen     (listen),
        .leds       (leds)
    );

    level_store i_level_store (
        .clk          (clk),
        .load         (load),
        .level_select (level_select),
        .next_level   (next_level),
        .level        (level),
        .level_number (level_number)
    );

    note_playback #(
        .note_cycles(note_cycles)
    ) i_note_playback (
        .clk       (clk),
        .load      (load),
        .arm       (arm),
        .play      (play),
        .level     (level),
        .play_note (play_note),
        .play_done (play_done)
    );

    response_checker i_response_checker (
        .clk      (clk),
        .load     (load),
        .arm      (arm),
        .listen   (listen),
        .buttons  (buttons),
        .level    (level),
        .response (response)
    );

    segment_display i_segment_display (
        .state        (state),
        .level_number (level_number),
        .display      (display)
    );

endmodule

`default_nettype wire

// File: segment_display.sv
`timescale 1ns/1ps
`default_nettype none

module segment_display (
    input  wire game_pkg::game_state_e  state,
    input  wire game_pkg::level_num_t   level_number,
    output display_pkg::display_t       display
);

    display_pkg::seg_t level_digit;

    assign level_digit = display_pkg::hex_glyph(level_number);

    always_comb
    begin
        case (state)
            game_pkg::st_idle:
                display = {display_pkg::glyph_h, display_pkg::glyph_e, display_pkg::glyph_l,
                           display_pkg::glyph_l, display_pkg::glyph_o, display_pkg::glyph_blank};
            game_pkg::st_challenge:
                display = {display_pkg::glyph_s, display_pkg::glyph_t, display_pkg::glyph_a,
                           display_pkg::glyph_g, display_pkg::glyph_e, level_digit};
            game_pkg::st_listen:
                display = {display_pkg::glyph_t, display_pkg::glyph_u, display_pkg::glyph_r,
                           display_pkg::glyph_n, display_pkg::glyph_blank,
                           display_pkg::glyph_blank};
            game_pkg::st_won:
                display = {display_pkg::glyph_s, display_pkg::glyph_c, display_pkg::glyph_o,
                           display_pkg::glyph_r, display_pkg::glyph_e, display_pkg::glyph_blank};
            game_pkg::st_lost:
                display = {display_pkg::glyph_l, display_pkg::glyph_o, display_pkg::glyph_s,
                           display_pkg::glyph_e, display_pkg::glyph_blank,
                           display_pkg::glyph_blank};
            // short transit states stay dark
            default:
                display = {6{display_pkg::glyph_blank}};
        endcase
    end

endmodule

`default_nettype wire

// File: game_controller.sv
`timescale 1ns/1ps
`default_nettype none

module game_controller #(
    parameter int win_pause_cycles = 50000000
) (
    input  wire logic                   clk,
    input  wire logic                   load,
    input  wire logic                   start_game,
    input  wire logic                   play_done,
    input  wire game_pkg::response_t    response,
    input  wire game_pkg::note_t        buttons,
    input  wire game_pkg::note_t        play_note,
    output game_pkg::game_state_e       state,
    output logic                        next_level,
    output logic                        arm,
    output logic                        play,
    output logic                        listen,
    output game_pkg::note_t             leds
);

    localparam int pause_w = $clog2(win_pause_cycles + 1);

    game_pkg::game_state_e  state_nxt;
    logic [pause_w-1:0]     pause_count;
    logic                   pause_done;

    assign pause_done = (pause_count == pause_w'(win_pause_cycles - 1));

    always_comb
    begin
        state_nxt = state;
        case (state)
            game_pkg::st_idle:
                if (start_game)
                    state_nxt = game_pkg::st_next_level;
            game_pkg::st_next_level:
                state_nxt = game_pkg::st_arm;
            game_pkg::st_arm:
                state_nxt = game_pkg::st_challenge;
            game_pkg::st_challenge:
                if (play_done)
                    state_nxt = game_pkg::st_listen;
            game_pkg::st_listen:
                // mistake wins over last
                if (response.press && response.mistake)
                    state_nxt = game_pkg::st_lost;
                else if (response.press && response.last)
                    state_nxt = game_pkg::st_won;
            game_pkg::st_won:
                if (pause_done)
                    state_nxt = game_pkg::st_next_level;
            game_pkg::st_lost:
                state_nxt = game_pkg::st_lost;
            default:
                state_nxt = game_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            state <= game_pkg::st_idle;
        else
            state <= state_nxt;
    end

    // win pause runs only while in st_won
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            pause_count <= '0;
        else if (state != game_pkg::st_won)
            pause_count <= '0;
        else
            pause_count <= pause_count + 1'b1;
    end

    assign next_level = (state == game_pkg::st_next_level);
    assign arm        = (state == game_pkg::st_arm);
    assign play       = (state == game_pkg::st_challenge);
    assign listen     = (state == game_pkg::st_listen);

    // leds follow the buttons except during playback
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            leds <= '0;
        else if (state == game_pkg::st_challenge)
            leds <= play_note;
        else
            leds <= buttons;
    end

endmodule

`default_nettype wire

// File: response_checker.sv
`timescale 1ns/1ps
`default_nettype none

module response_checker (
    input  wire logic               clk,
    input  wire logic               load,
    input  wire logic               arm,
    input  wire logic               listen,
    input  wire game_pkg::note_t    buttons,
    input  wire game_pkg::level_t   level,
    output game_pkg::response_t     response
);

    game_pkg::note_t    prev_buttons;
    logic [2:0]         expect_idx;
    logic               press_now;
    game_pkg::note_t    expected;

    // press is a release-to-pressed edge
    assign press_now = listen && (prev_buttons == '0) && (buttons != '0);
    assign expected  = level.notes[expect_idx];

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            prev_buttons <= '0;
        else
            prev_buttons <= buttons;
    end

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            expect_idx <= '0;
        else if (arm)
            expect_idx <= '0;
        else if (press_now)
            expect_idx <= expect_idx + 1'b1;
    end

    // checked against the index before it advances
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            response <= '0;
        end
        else
        begin
            response.press   <= press_now;
            response.mistake <= press_now && (buttons != expected);
            response.last    <= press_now && ({1'b0, expect_idx} == level.length - 4'd1);
        end
    end

endmodule

`default_nettype wire

// File: note_playback.sv
`timescale 1ns/1ps
`default_nettype none

module note_playback #(
    parameter int note_cycles = 25000000
) (
    input  wire logic               clk,
    input  wire logic               load,
    input  wire logic               arm,
    input  wire logic               play,
    input  wire game_pkg::level_t   level,
    output game_pkg::note_t         play_note,
    output logic                    play_done
);

    localparam int timer_w = $clog2(note_cycles + 1);

    logic [timer_w-1:0] slot_timer;
    logic [2:0]         note_idx;
    logic               dark;
    logic               slot_end;
    logic               last_note;

    assign slot_end  = (slot_timer == timer_w'(note_cycles - 1));
    assign last_note = ({1'b0, note_idx} == level.length - 4'd1);

    // each note gets a lit slot then a dark slot
    always_ff @(posedge clk or posedge load)
    begin
        if (load)
        begin
            slot_timer <= '0;
            note_idx   <= '0;
            dark       <= 1'b0;
            play_done  <= 1'b0;
        end
        else if (arm)
        begin
            slot_timer <= '0;
            note_idx   <= '0;
            dark       <= 1'b0;
            play_done  <= 1'b0;
        end
        else if (play && !play_done)
        begin
            if (!slot_end)
                slot_timer <= slot_timer + 1'b1;
            else
            begin
                slot_timer <= '0;
                if (!dark)
                    dark <= 1'b1;
                else if (last_note)
                    play_done <= 1'b1;
                else
                begin
                    note_idx <= note_idx + 1'b1;
                    dark     <= 1'b0;
                end
            end
        end
    end

    assign play_note = (play && !dark && !play_done) ? level.notes[note_idx] : '0;

endmodule

`default_nettype wire

// File: level_store.sv
`timescale 1ns/1ps
`default_nettype none

module level_store (
    input  wire logic                   clk,
    input  wire logic                   load,
    input  wire game_pkg::level_num_t   level_select,
    input  wire logic                   next_level,
    output game_pkg::level_t            level,
    output game_pkg::level_num_t        level_number
);

    logic [15:0]                                    lfsr;
    logic                                           feedback;
    game_pkg::note_t [game_pkg::max_notes-1:0]      random_notes;

    // first argument is the note count, then notes in play order
    function automatic game_pkg::level_t make_level(
        input logic [3:0]      len,
        input game_pkg::note_t n0,
        input game_pkg::note_t n1,
        input game_pkg::note_t n2,
        input game_pkg::note_t n3,
        input game_pkg::note_t n4,
        input game_pkg::note_t n5
    );
        game_pkg::level_t lvl;
        lvl.length = len;
        lvl.notes  = {n5, n4, n3, n2, n1, n0};
        return lvl;
    endfunction

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            level_number <= level_select;
        else if (next_level && level_number != game_pkg::max_level)
            level_number <= level_number + 1'b1;
    end

    // taps 16,14,13,11
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    always_ff @(posedge clk or posedge load)
    begin
        if (load)
            lfsr <= 16'hace1;
        else
            lfsr <= {lfsr[14:0], feedback};
    end

    // two lfsr bits pick one of four buttons
    always_ff @(posedge clk)
    begin
        if (next_level)
        begin
            for (int i = 0; i < game_pkg::max_notes; i++)
            begin
                random_notes[i] <= game_pkg::note_t'(4'b0001 << lfsr[2*i +: 2]);
            end
        end
    end

    always_comb
    begin
        case (level_number)
            4'd0: level = make_level(4'd0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0, 4'h0);
            4'd1: level = make_level(4'd4, 4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0);
            4'd2: level = make_level(4'd4, 4'h1, 4'h2, 4'h4, 4'h8, 4'h0, 4'h0);
            4'd3: level = make_level(4'd5, 4'h1, 4'h2, 4'h2, 4'h1, 4'h1, 4'h0);
            4'd4: level = make_level(4'd6, 4'h4, 4'h2, 4'h1, 4'h4, 4'h2, 4'h1);
            default:
            begin
                level.length = 4'(game_pkg::max_notes);
                level.notes  = random_notes;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: display_pkg.sv
`default_nettype none

package display_pkg;

    // active low, segment g in bit 6
    typedef logic [6:0] seg_t;

    typedef struct packed {
        seg_t hex5;
        seg_t hex4;
        seg_t hex3;
        seg_t hex2;
        seg_t hex1;
        seg_t hex0;
    } display_t;

    localparam seg_t glyph_h     = 7'b000_1001;
    localparam seg_t glyph_e     = 7'b000_0110;
    localparam seg_t glyph_l     = 7'b100_0111;
    localparam seg_t glyph_o     = 7'b100_0000;
    localparam seg_t glyph_s     = 7'b001_0010;
    localparam seg_t glyph_t     = 7'b000_0111;
    localparam seg_t glyph_a     = 7'b000_1000;
    localparam seg_t glyph_g     = 7'b100_0010;
    localparam seg_t glyph_u     = 7'b100_0001;
    localparam seg_t glyph_r     = 7'b010_1111;
    localparam seg_t glyph_n     = 7'b010_1011;
    localparam seg_t glyph_c     = 7'b100_0110;
    localparam seg_t glyph_blank = 7'b111_1111;

    function automatic seg_t hex_glyph(input logic [3:0] value);
        seg_t seg;
        case (value)
            4'h0: seg = 7'b100_0000;
            4'h1: seg = 7'b111_1001;
            4'h2: seg = 7'b010_0100;
            4'h3: seg = 7'b011_0000;
            4'h4: seg = 7'b001_1001;
            4'h5: seg = 7'b001_0010;
            4'h6: seg = 7'b000_0010;
            4'h7: seg = 7'b111_1000;
            4'h8: seg = 7'b000_0000;
            4'h9: seg = 7'b001_1000;
            4'ha: seg = 7'b000_1000;
            4'hb: seg = 7'b000_0011;
            4'hc: seg = 7'b100_0110;
            4'hd: seg = 7'b010_0001;
            4'he: seg = 7'b000_0110;
            default: seg = 7'b000_1110;
        endcase
        return seg;
    endfunction

endpackage

`default_nettype wire

// File: game_pkg.sv
`default_nettype none

package game_pkg;

    // one-hot note, one bit per button or LED
    typedef logic [3:0] note_t;

    localparam int max_notes = 6;

    typedef logic [3:0] level_num_t;

    // highest level the counter reaches
    localparam level_num_t max_level = 4'd15;

    // notes[0] plays first
    typedef struct packed {
        logic [3:0]                  length;
        note_t [max_notes-1:0]       notes;
    } level_t;

    typedef enum logic [2:0] {
        st_idle,
        st_next_level,
        st_arm,
        st_challenge,
        st_listen,
        st_won,
        st_lost
    } game_state_e;

    typedef struct packed {
        logic press;
        logic mistake;
        logic last;
    } response_t;

endpackage

`default_nettype wire
